/* all.f */
+incdir+source
+incdir+sim
source/debug_overlay_pkg.sv
source/glyph_rom.sv
source/bin_to_bcd.sv
source/text_line_render.sv
source/debug_value_render.sv
source/overlay_mixer.sv
source/debug_overlay_top.sv
sim/tb_debug_overlay.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_debug_overlay
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* sim/overlay_model.svh */
`ifndef OVERLAY_MODEL_SVH
`define OVERLAY_MODEL_SVH

`include "debug_overlay_config.svh"

// glyph rows top screen line first, bit 7 is the leftmost column
localparam logic [7:0] FONT_TABLE [11][8] = '{
    '{8'h3c, 8'h42, 8'h46, 8'h4a, 8'h52, 8'h62, 8'h42, 8'h3c},   // 0
    '{8'h18, 8'h28, 8'h48, 8'h08, 8'h08, 8'h08, 8'h08, 8'h7e},   // 1
    '{8'h3c, 8'h42, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h7e},   // 2
    '{8'h3c, 8'h42, 8'h02, 8'h1c, 8'h02, 8'h02, 8'h42, 8'h3c},   // 3
    '{8'h04, 8'h0c, 8'h14, 8'h24, 8'h44, 8'h7e, 8'h04, 8'h04},   // 4
    '{8'h7e, 8'h40, 8'h40, 8'h7c, 8'h02, 8'h02, 8'h42, 8'h3c},   // 5
    '{8'h3c, 8'h40, 8'h40, 8'h7c, 8'h42, 8'h42, 8'h42, 8'h3c},   // 6
    '{8'h7e, 8'h02, 8'h04, 8'h08, 8'h10, 8'h10, 8'h10, 8'h10},   // 7
    '{8'h3c, 8'h42, 8'h42, 8'h3c, 8'h42, 8'h42, 8'h42, 8'h3c},   // 8
    '{8'h3c, 8'h42, 8'h42, 8'h3e, 8'h02, 8'h02, 8'h02, 8'h3c},   // 9
    '{8'h00, 8'h00, 8'h00, 8'h00, 8'h7e, 8'h00, 8'h00, 8'h00}    // minus
};

function automatic logic [7:0] font_bits(input debug_overlay_pkg::glyph_code_t code,
                                         input logic [2:0] line);
    if (code > debug_overlay_pkg::GLYPH_MINUS)
        return 8'h00;   // blank
    return FONT_TABLE[code][line];
endfunction

// what the overlay should show for one input pixel
function automatic debug_overlay_pkg::pixel_t expected_pixel(
        input debug_overlay_pkg::pixel_t  pix,
        input debug_overlay_pkg::raster_t pos,
        input logic [`DBG_VALUE_W-1:0]    disp);
    int                             col;
    int                             line;
    int                             slot;
    int                             mag;
    int                             place;
    logic [2:0]                     bcol;
    logic [7:0]                     bits;
    debug_overlay_pkg::glyph_code_t code;
    debug_overlay_pkg::pixel_t      black;
    debug_overlay_pkg::pixel_t      white;

    black = debug_overlay_pkg::pixel_t'(12'h000);
    white = debug_overlay_pkg::pixel_t'(12'hfff);
    col   = int'(pos.x) - `DBG_ORIGIN_X;
    line  = int'(pos.y) - `DBG_ORIGIN_Y;
    if (!pos.active || col < 0 || col >= `DBG_LINE_W || line < 0 || line >= `DBG_FONT_W)
        return pix;
    slot = col / `DBG_FONT_W;   // 0 is the sign slot
    mag  = disp[`DBG_VALUE_W-1] ? 65536 - int'(disp) : int'(disp);
    if (slot == 0) begin
        code = disp[`DBG_VALUE_W-1] ? debug_overlay_pkg::GLYPH_MINUS
                                    : debug_overlay_pkg::GLYPH_BLANK;
    end else begin
        place = 1;
        for (int i = slot; i < `DBG_GLYPHS - 1; i++)
            place = place * 10;   // slot 1 is the ten-thousands digit
        code = 4'((mag / place) % 10);
    end
    bits = font_bits(code, 3'(line));
    bcol = 3'(col % `DBG_FONT_W);
    return bits[3'd7 - bcol] ? black : white;
endfunction

`endif

/* sim/tb_debug_overlay.sv */
`timescale 1ns/1ns
`include "debug_overlay_config.svh"

module tb_debug_overlay;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_W      = 96;
    localparam int LINE_CYCLES  = FRAME_W + 2;   // two blanking columns
    localparam int FRAME_H      = 32;
    localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_H;
    localparam int NUM_FRAMES   = 7;
    localparam int QUIET_LINES  = 4;   // no random loads near the bottom
    localparam int MARGIN       = 200;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + MARGIN) * CLK_PERIOD;
    localparam int CW           = `DBG_COORD_W;

    localparam logic [`DBG_VALUE_W-1:0] FORCED [4] = '{16'h0000, 16'hffff, 16'h7fff, 16'h8000};

    logic                       clk;
    logic                       rst_n;
    logic [`DBG_VALUE_W-1:0]    value;
    logic                       value_load;
    logic                       frame_start;
    debug_overlay_pkg::pixel_t  pix_in;
    debug_overlay_pkg::raster_t pos;
    debug_overlay_pkg::pixel_t  pix_out;
    logic                       out_active;

    logic [`DBG_VALUE_W-1:0]    shadow_m;
    logic [`DBG_VALUE_W-1:0]    disp_m;
    debug_overlay_pkg::pixel_t  exp_pix_q [$];
    logic                       exp_act_q [$];

    `include "overlay_model.svh"

    debug_overlay_top i_debug_overlay_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .value       (value),
        .value_load  (value_load),
        .frame_start (frame_start),
        .pix_in      (pix_in),
        .pos         (pos),
        .pix_out     (pix_out),
        .out_active  (out_active)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic halt_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input debug_overlay_pkg::pixel_t exp,
                               input debug_overlay_pkg::pixel_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            halt_run();
        end
    endtask

    task automatic check_active(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            halt_run();
        end
    endtask

    // one stream cycle, model first, then the DUT inputs
    task automatic drive_cycle(input logic rst, input debug_overlay_pkg::pixel_t pix,
                               input debug_overlay_pkg::raster_t p, input logic load,
                               input logic [`DBG_VALUE_W-1:0] val, input logic fs);
        debug_overlay_pkg::pixel_t zero_pix;

        zero_pix = '0;
        if (!rst) begin
            shadow_m = '0;
            disp_m   = '0;
            exp_pix_q.push_back(zero_pix);   // pipeline held in reset
            exp_act_q.push_back(1'b0);
        end else begin
            if (fs)
                disp_m = shadow_m;   // old shadow wins on a coincident load
            if (load)
                shadow_m = val;
            exp_pix_q.push_back(expected_pixel(pix, p, disp_m));
            exp_act_q.push_back(p.active);
        end
        rst_n       <= rst;
        pix_in      <= pix;
        pos         <= p;
        value_load  <= load;
        value       <= val;
        frame_start <= fs;
    endtask

    initial begin : stimulus
        logic [31:0]                seed;
        debug_overlay_pkg::raster_t p;
        debug_overlay_pkg::pixel_t  pix;
        logic                       load;
        logic [`DBG_VALUE_W-1:0]    val;

        seed        = 32'h79c8_1751;
        rst_n       = 1'b0;
        value       = '0;
        value_load  = 1'b0;
        frame_start = 1'b0;
        pix_in      = '0;
        pos         = '0;
        shadow_m    = '0;
        disp_m      = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            seed = lcg_next(seed);
            drive_cycle(1'b0, debug_overlay_pkg::pixel_t'(seed[27:16]), '0, 1'b0, '0, 1'b0);
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int y = 0; y < FRAME_H; y++) begin
                for (int x = 0; x < LINE_CYCLES; x++) begin
                    @(posedge clk);
                    seed     = lcg_next(seed);
                    pix      = debug_overlay_pkg::pixel_t'(seed[27:16]);
                    p.x      = CW'(x);
                    p.y      = CW'(y);
                    p.active = (x < FRAME_W);
                    seed     = lcg_next(seed);
                    load     = (y < FRAME_H - QUIET_LINES) && (seed[31:24] == 8'h00);
                    seed     = lcg_next(seed);
                    val      = seed[31:16];
                    if (f < 4 && y == FRAME_H - QUIET_LINES && x == 0) begin
                        load = 1'b1;   // corner value, shown in the next frame
                        val  = FORCED[2'(f)];
                    end
                    if (f == 5 && x == 0 && y == 0)
                        load = 1'b1;   // load on the frame_start edge
                    drive_cycle(1'b1, pix, p, load, val, (x == 0 && y == 0));
                end
            end
        end
        repeat (3) begin
            @(posedge clk);
            drive_cycle(1'b1, '0, '0, 1'b0, '0, 1'b0);
        end
        repeat (2) @(negedge clk);
        $display("No errors");
        $finish;
    end

    // outputs settle after the rising edge, compare midway
    always @(negedge clk) begin
        if (exp_pix_q.size() > 2) begin
            check_pixel("pix_out", exp_pix_q.pop_front(), pix_out);
            check_active("out_active", exp_act_q.pop_front(), out_active);
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        halt_run();
    end

endmodule

/* source/debug_overlay_top.sv */
`timescale 1ns/1ns
`include "debug_overlay_config.svh"

module debug_overlay_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`DBG_VALUE_W-1:0]    value,
    input  logic                       value_load,
    input  logic                       frame_start,
    input  debug_overlay_pkg::pixel_t  pix_in,
    input  debug_overlay_pkg::raster_t pos,
    output debug_overlay_pkg::pixel_t  pix_out,
    output logic                       out_active
);

    logic [`DBG_VALUE_W-1:0]        disp_value;
    logic [$clog2(`DBG_FONT_W)-1:0] glyph_row;
    logic [`DBG_LINE_W-1:0]         line_bits;   // combinational return path

    overlay_mixer i_overlay_mixer (
        .clk         (clk),
        .rst_n       (rst_n),
        .value       (value),
        .value_load  (value_load),
        .frame_start (frame_start),
        .pix_in      (pix_in),
        .pos         (pos),
        .line_bits   (line_bits),
        .disp_value  (disp_value),
        .glyph_row   (glyph_row),
        .pix_out     (pix_out),
        .out_active  (out_active)
    );

    debug_value_render i_debug_value_render (
        .value     (disp_value),
        .row       (glyph_row),
        .line_bits (line_bits)
    );

endmodule

/* source/overlay_mixer.sv */
`timescale 1ns/1ns
`include "debug_overlay_config.svh"

module overlay_mixer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [`DBG_VALUE_W-1:0]           value,
    input  logic                              value_load,
    input  logic                              frame_start,
    input  debug_overlay_pkg::pixel_t         pix_in,
    input  debug_overlay_pkg::raster_t        pos,
    input  logic [`DBG_LINE_W-1:0]            line_bits,
    output logic [`DBG_VALUE_W-1:0]           disp_value,
    output logic [$clog2(`DBG_FONT_W)-1:0]    glyph_row,
    output debug_overlay_pkg::pixel_t         pix_out,
    output logic                              out_active
);

    localparam int COORD_W = `DBG_COORD_W;
    localparam int ROW_W   = $clog2(`DBG_FONT_W);
    localparam int COL_W   = $clog2(`DBG_LINE_W);

    localparam debug_overlay_pkg::pixel_t INK   = '0;   // black
    localparam debug_overlay_pkg::pixel_t PAPER = '1;   // white

    logic [`DBG_VALUE_W-1:0]   shadow_value;
    logic [COORD_W-1:0]        dx;
    logic [COORD_W-1:0]        dy;
    logic                      in_win;
    debug_overlay_pkg::pixel_t s1_pix;
    logic                      s1_active;
    logic                      s1_in_win;
    logic [ROW_W-1:0]          s1_row;
    logic [COL_W-1:0]          s1_col;
    logic [COL_W-1:0]          bit_idx;
    logic [`DBG_LINE_W-1:0]    line_bits_q;
    logic                      chk_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shadow_value <= '0;
            disp_value   <= '0;
        end else begin
            if (value_load)
                shadow_value <= value;
            if (frame_start)
                disp_value <= shadow_value;   // a coincident load waits one frame
        end
    end

    // offsets wrap when left of or above the origin
    assign dx     = pos.x - COORD_W'(`DBG_ORIGIN_X);
    assign dy     = pos.y - COORD_W'(`DBG_ORIGIN_Y);
    assign in_win = pos.active && (dx < COORD_W'(`DBG_LINE_W)) && (dy < COORD_W'(`DBG_FONT_W));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_pix    <= '0;
            s1_active <= 1'b0;
            s1_in_win <= 1'b0;
        end else begin
            s1_pix    <= pix_in;
            s1_active <= pos.active;
            s1_in_win <= in_win;
        end
    end

    always_ff @(posedge clk) begin
        s1_row <= ~dy[ROW_W-1:0];   // top screen line is font row 7
        s1_col <= dx[COL_W-1:0];
    end

    assign glyph_row = s1_row;
    assign bit_idx   = COL_W'(`DBG_LINE_W - 1) - s1_col;   // column 0 is line bit 47

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_out    <= '0;
            out_active <= 1'b0;
        end else begin
            out_active <= s1_active;
            if (s1_in_win)
                pix_out <= line_bits[bit_idx] ? INK : PAPER;
            else
                pix_out <= s1_pix;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            chk_valid <= 1'b0;
        else
            chk_valid <= s1_in_win;
    end

    always_ff @(posedge clk) begin
        line_bits_q <= line_bits;
    end

    a_frame_start_origin: assert property (@(posedge clk) disable iff (!rst_n)
        frame_start |-> (pos.x == '0 && pos.y == '0));

    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!out_active && pix_out == '0) ##1 (!out_active && pix_out == '0));

    // every 0-9 glyph has ink on each row, so an empty slot means a digit above 9
    for (genvar g = 0; g < `DBG_BCD_DIGITS; g++) begin : g_digit_check
        a_digit_range: assert property (@(posedge clk) disable iff (!rst_n)
            chk_valid |-> (line_bits_q[g*`DBG_FONT_W +: `DBG_FONT_W] != '0));
    end

endmodule

/* source/debug_value_render.sv */
`timescale 1ns/1ns
`include "debug_overlay_config.svh"

module debug_value_render (
    input  logic [`DBG_VALUE_W-1:0]        value,
    input  logic [$clog2(`DBG_FONT_W)-1:0] row,
    output logic [`DBG_LINE_W-1:0]         line_bits
);

    logic                          negative;
    logic [`DBG_VALUE_W-1:0]       magnitude;
    logic [4*`DBG_BCD_DIGITS-1:0]  bcd;

    assign negative  = value[`DBG_VALUE_W-1];
    assign magnitude = negative ? (~value + 1'b1) : value;   // 16'h8000 reads as 32768 unsigned

    bin_to_bcd i_bin_to_bcd (
        .bin (magnitude),
        .bcd (bcd)
    );

    text_line_render i_text_line_render (
        .bcd       (bcd),
        .negative  (negative),
        .row       (row),
        .line_bits (line_bits)
    );

endmodule

/* source/text_line_render.sv */
`timescale 1ns/1ns
`include "debug_overlay_config.svh"

module text_line_render (
    input  logic [4*`DBG_BCD_DIGITS-1:0]   bcd,
    input  logic                           negative,
    input  logic [$clog2(`DBG_FONT_W)-1:0] row,
    output logic [`DBG_LINE_W-1:0]         line_bits
);

    debug_overlay_pkg::glyph_code_t codes [`DBG_GLYPHS];

    // glyph 0 is the units digit, top glyph is the sign
    always_comb begin
        for (int g = 0; g < `DBG_BCD_DIGITS; g++) begin
            codes[g] = bcd[4*g +: 4];
        end
        codes[`DBG_GLYPHS-1] = negative ? debug_overlay_pkg::GLYPH_MINUS
                                        : debug_overlay_pkg::GLYPH_BLANK;
    end

    for (genvar g = 0; g < `DBG_GLYPHS; g++) begin : g_glyph
        glyph_rom i_glyph_rom (
            .digit      (codes[g]),
            .row        (row),
            .bitmap_row (line_bits[g*`DBG_FONT_W +: `DBG_FONT_W])
        );
    end

endmodule

/* source/bin_to_bcd.sv */
`timescale 1ns/1ns
`include "debug_overlay_config.svh"

module bin_to_bcd (
    input  logic [`DBG_VALUE_W-1:0]      bin,
    output logic [4*`DBG_BCD_DIGITS-1:0] bcd
);

    localparam int BIN_W = `DBG_VALUE_W;
    localparam int BCD_W = 4 * `DBG_BCD_DIGITS;

    // double dabble, bcd field sits above the binary field
    always_comb begin : dabble
        logic [BIN_W+BCD_W-1:0] sr;

        sr = '0;
        sr[BIN_W-1:0] = bin;
        for (int i = 0; i < BIN_W; i++) begin
            for (int j = 0; j < `DBG_BCD_DIGITS; j++) begin
                if (sr[BIN_W + 4*j +: 4] >= 4'd5)
                    sr[BIN_W + 4*j +: 4] = sr[BIN_W + 4*j +: 4] + 4'd3;
            end
            sr = sr << 1;
        end
        bcd = sr[BIN_W +: BCD_W];   // 5 digits hold up to 65535
    end

endmodule

/* source/glyph_rom.sv */
`timescale 1ns/1ns
`include "debug_overlay_config.svh"

module glyph_rom (
    input  debug_overlay_pkg::glyph_code_t     digit,
    input  logic [$clog2(`DBG_FONT_W)-1:0]     row,
    output logic [`DBG_FONT_W-1:0]             bitmap_row
);

    // row 7 is the top line, bit 7 the leftmost column
    always_comb begin
        bitmap_row = '0;   // blank and unused codes
        case (digit)
            4'd0: case (row)
                3'd7: bitmap_row = 8'b00111100;
                3'd6: bitmap_row = 8'b01000010;
                3'd5: bitmap_row = 8'b01000110;
                3'd4: bitmap_row = 8'b01001010;
                3'd3: bitmap_row = 8'b01010010;
                3'd2: bitmap_row = 8'b01100010;
                3'd1: bitmap_row = 8'b01000010;
                3'd0: bitmap_row = 8'b00111100;
            endcase
            4'd1: case (row)
                3'd7: bitmap_row = 8'b00011000;
                3'd6: bitmap_row = 8'b00101000;
                3'd5: bitmap_row = 8'b01001000;
                3'd4: bitmap_row = 8'b00001000;
                3'd3: bitmap_row = 8'b00001000;
                3'd2: bitmap_row = 8'b00001000;
                3'd1: bitmap_row = 8'b00001000;
                3'd0: bitmap_row = 8'b01111110;   // foot
            endcase
            4'd2: case (row)
                3'd7: bitmap_row = 8'b00111100;
                3'd6: bitmap_row = 8'b01000010;
                3'd5: bitmap_row = 8'b00000010;
                3'd4: bitmap_row = 8'b00000100;
                3'd3: bitmap_row = 8'b00001000;
                3'd2: bitmap_row = 8'b00010000;
                3'd1: bitmap_row = 8'b00100000;
                3'd0: bitmap_row = 8'b01111110;
            endcase
            4'd3: case (row)
                3'd7: bitmap_row = 8'b00111100;
                3'd6: bitmap_row = 8'b01000010;
                3'd5: bitmap_row = 8'b00000010;
                3'd4: bitmap_row = 8'b00011100;   // middle stroke
                3'd3: bitmap_row = 8'b00000010;
                3'd2: bitmap_row = 8'b00000010;
                3'd1: bitmap_row = 8'b01000010;
                3'd0: bitmap_row = 8'b00111100;
            endcase
            4'd4: case (row)
                3'd7: bitmap_row = 8'b00000100;
                3'd6: bitmap_row = 8'b00001100;
                3'd5: bitmap_row = 8'b00010100;
                3'd4: bitmap_row = 8'b00100100;
                3'd3: bitmap_row = 8'b01000100;
                3'd2: bitmap_row = 8'b01111110;
                3'd1: bitmap_row = 8'b00000100;
                3'd0: bitmap_row = 8'b00000100;
            endcase
            4'd5: case (row)
                3'd7: bitmap_row = 8'b01111110;
                3'd6: bitmap_row = 8'b01000000;
                3'd5: bitmap_row = 8'b01000000;
                3'd4: bitmap_row = 8'b01111100;
                3'd3: bitmap_row = 8'b00000010;
                3'd2: bitmap_row = 8'b00000010;
                3'd1: bitmap_row = 8'b01000010;
                3'd0: bitmap_row = 8'b00111100;
            endcase
            4'd6: case (row)
                3'd7: bitmap_row = 8'b00111100;
                3'd6: bitmap_row = 8'b01000000;
                3'd5: bitmap_row = 8'b01000000;
                3'd4: bitmap_row = 8'b01111100;
                3'd3: bitmap_row = 8'b01000010;
                3'd2: bitmap_row = 8'b01000010;
                3'd1: bitmap_row = 8'b01000010;
                3'd0: bitmap_row = 8'b00111100;
            endcase
            4'd7: case (row)
                3'd7: bitmap_row = 8'b01111110;
                3'd6: bitmap_row = 8'b00000010;
                3'd5: bitmap_row = 8'b00000100;
                3'd4: bitmap_row = 8'b00001000;
                3'd3: bitmap_row = 8'b00010000;   // stem down to the base
                3'd2: bitmap_row = 8'b00010000;
                3'd1: bitmap_row = 8'b00010000;
                3'd0: bitmap_row = 8'b00010000;
            endcase
            4'd8: case (row)
                3'd7: bitmap_row = 8'b00111100;
                3'd6: bitmap_row = 8'b01000010;
                3'd5: bitmap_row = 8'b01000010;
                3'd4: bitmap_row = 8'b00111100;
                3'd3: bitmap_row = 8'b01000010;
                3'd2: bitmap_row = 8'b01000010;
                3'd1: bitmap_row = 8'b01000010;
                3'd0: bitmap_row = 8'b00111100;
            endcase
            4'd9: case (row)
                3'd7: bitmap_row = 8'b00111100;
                3'd6: bitmap_row = 8'b01000010;
                3'd5: bitmap_row = 8'b01000010;
                3'd4: bitmap_row = 8'b00111110;
                3'd3: bitmap_row = 8'b00000010;
                3'd2: bitmap_row = 8'b00000010;
                3'd1: bitmap_row = 8'b00000010;
                3'd0: bitmap_row = 8'b00111100;
            endcase
            debug_overlay_pkg::GLYPH_MINUS: begin
                if (row == 3'd3)
                    bitmap_row = 8'b01111110;   // bar just below mid height
            end
            default: bitmap_row = '0;
        endcase
    end

endmodule

/* source/debug_overlay_pkg.sv */
`include "debug_overlay_config.svh"

package debug_overlay_pkg;

    localparam int unsigned CHAN_W = `DBG_PIXEL_W / 3;

    typedef struct packed {
        logic [CHAN_W-1:0] r;
        logic [CHAN_W-1:0] g;
        logic [CHAN_W-1:0] b;
    } pixel_t;

    // position of the pixel on the same cycle
    typedef struct packed {
        logic [`DBG_COORD_W-1:0] x;
        logic [`DBG_COORD_W-1:0] y;
        logic                    active;   // low in blanking
    } raster_t;

    typedef logic [3:0] glyph_code_t;   // 0-9 digits, see codes below

    localparam glyph_code_t GLYPH_MINUS = 4'd10;
    localparam glyph_code_t GLYPH_BLANK = 4'd15;

endpackage

/* source/debug_overlay_config.svh */
`ifndef DEBUG_OVERLAY_CONFIG_SVH
`define DEBUG_OVERLAY_CONFIG_SVH

`define DBG_VALUE_W     16   // signed value shown on screen
`define DBG_BCD_DIGITS  5    // magnitude digits
`define DBG_GLYPHS      6    // digits plus sign glyph
`define DBG_FONT_W      8    // glyph width and height

`define DBG_PIXEL_W     12   // 4:4:4 rgb
`define DBG_LINE_W      48   // one text row across all glyphs

`define DBG_ORIGIN_X    32   // top-left corner of the text window
`define DBG_ORIGIN_Y    16
`define DBG_COORD_W     11   // raster x/y width

`endif
